//--- design/linear_pkg.sv
package linear_pkg;

  // Element format, signed Q3.4
  localparam int DATA_W    = 8;
  localparam int DATA_FRAC = 4;

  // Accumulator format
  // 16-bit products summed over up to 16 features fit in 20 bits
  localparam int ACC_W    = 20;
  localparam int ACC_FRAC = 2 * DATA_FRAC;

  // Inputs, weights, biases and outputs share one element type
  typedef logic signed [DATA_W-1:0] elem_t;

  typedef logic signed [ACC_W-1:0] acc_t;

  // Index width for a count of n, at least one bit
  function automatic int idx_w(input int n);
    int w;
    w = (n > 1) ? $clog2(n) : 1;
    return w;
  endfunction

endpackage

//--- design/stream_register_slice.sv
`timescale 1ns/1ps

module stream_register_slice #(
  parameter type T = logic [7:0]
) (
  input  logic clk,
  input  logic i_rst_n,
  input  T     i_data,
  input  logic i_valid,
  output logic o_ready,
  output T     o_data,
  output logic o_valid,
  input  logic i_ready
);

  T     main_q;
  T     spare_q;
  logic main_vld_q;
  logic spare_vld_q;
  logic ready_q;
  logic main_vld_d;
  logic spare_vld_d;
  logic in_fire;
  logic out_fire;

  assign in_fire  = i_valid && ready_q;
  assign out_fire = main_vld_q && i_ready;

  // Occupancy of the main and spare registers
  always_comb begin
    main_vld_d  = main_vld_q;
    spare_vld_d = spare_vld_q;
    if (spare_vld_q) begin
      // Spare moves into main once main drains
      if (out_fire) begin
        spare_vld_d = 1'b0;
      end
    end else if (in_fire) begin
      if (main_vld_q && !out_fire) begin
        spare_vld_d = 1'b1;
      end else begin
        main_vld_d = 1'b1;
      end
    end else if (out_fire) begin
      main_vld_d = 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      main_vld_q  <= 1'b0;
      spare_vld_q <= 1'b0;
      ready_q     <= 1'b0;
    end else begin
      main_vld_q  <= main_vld_d;
      spare_vld_q <= spare_vld_d;
      // Ready is a flop, no path from i_ready
      ready_q     <= !spare_vld_d;
    end
  end

  always_ff @(posedge clk) begin
    if (spare_vld_q) begin
      if (out_fire) begin
        main_q <= spare_q;
      end
    end else if (in_fire) begin
      // Beat arriving during a stall parks in the spare
      if (main_vld_q && !out_fire) begin
        spare_q <= i_data;
      end else begin
        main_q <= i_data;
      end
    end
  end

  assign o_ready = ready_q;
  assign o_data  = main_q;
  assign o_valid = main_vld_q;

endmodule

//--- design/input_vector_buffer.sv
`timescale 1ns/1ps

module input_vector_buffer #(
  parameter  int IN_FEATURES = 4,
  localparam int COL_W       = linear_pkg::idx_w(IN_FEATURES)
) (
  input  logic              clk,
  input  logic              i_rst_n,
  input  linear_pkg::elem_t i_x_data,
  input  logic              i_x_valid,
  output logic              o_x_ready,
  input  logic [COL_W-1:0]  i_addr,
  output linear_pkg::elem_t o_elem,
  output logic              o_vec_full,
  input  logic              i_vec_release
);

  import linear_pkg::*;

  elem_t            vec_mem [IN_FEATURES];
  logic [COL_W-1:0] wr_cnt_q;
  logic             full_q;
  logic             x_fire;
  logic             last_wr;

  assign x_fire  = i_x_valid && o_x_ready;
  assign last_wr = (wr_cnt_q == COL_W'(IN_FEATURES - 1));

  // Fill counter and full flag
  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      wr_cnt_q <= '0;
      full_q   <= 1'b0;
    end else if (i_vec_release) begin
      full_q <= 1'b0;
    end else if (x_fire) begin
      if (last_wr) begin
        wr_cnt_q <= '0;
        full_q   <= 1'b1;
      end else begin
        wr_cnt_q <= wr_cnt_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (x_fire) begin
      vec_mem[wr_cnt_q] <= i_x_data;
    end
  end

  // Vector held until the engine lets go of it
  assign o_x_ready  = !full_q;
  assign o_vec_full = full_q;
  assign o_elem     = vec_mem[i_addr];

endmodule

//--- design/weight_store.sv
`timescale 1ns/1ps

module weight_store #(
  parameter  int IN_FEATURES  = 4,
  parameter  int OUT_FEATURES = 3,
  parameter  int HAS_BIAS     = 1,
  localparam int COL_W        = linear_pkg::idx_w(IN_FEATURES),
  localparam int ROW_W        = linear_pkg::idx_w(OUT_FEATURES)
) (
  input  logic              clk,
  input  logic              i_rst_n,
  input  linear_pkg::elem_t i_w_data,
  input  logic              i_w_valid,
  output logic              o_w_ready,
  input  linear_pkg::elem_t i_b_data,
  input  logic              i_b_valid,
  output logic              o_b_ready,
  input  logic              i_busy,
  input  logic [ROW_W-1:0]  i_row,
  input  logic [COL_W-1:0]  i_col,
  output linear_pkg::elem_t o_weight,
  output linear_pkg::elem_t o_bias,
  output logic              o_loaded
);

  import linear_pkg::*;

  localparam int W_TOTAL = IN_FEATURES * OUT_FEATURES;
  localparam int W_AW    = idx_w(W_TOTAL);

  // Load sequencer, OFF only for the cycle after reset
  typedef enum logic [1:0] {PH_OFF, PH_W, PH_B, PH_DONE} phase_t;

  phase_t           phase_q;
  elem_t            w_mem [W_TOTAL];
  elem_t            b_mem [OUT_FEATURES];
  logic [W_AW-1:0]  w_cnt_q;
  logic [ROW_W-1:0] b_cnt_q;
  logic [W_AW-1:0]  w_rd_addr;
  logic             w_fire;
  logic             b_fire;

  assign o_w_ready = !i_busy && ((phase_q == PH_W) || (phase_q == PH_DONE));
  assign o_b_ready = (HAS_BIAS != 0) && (phase_q == PH_B);
  assign w_fire    = i_w_valid && o_w_ready;
  assign b_fire    = i_b_valid && o_b_ready;

  // A weight beat while loaded starts a fresh matrix at address 0
  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      phase_q <= PH_OFF;
      w_cnt_q <= '0;
      b_cnt_q <= '0;
    end else begin
      if (phase_q == PH_OFF) begin
        phase_q <= PH_W;
      end
      if (w_fire) begin
        if (w_cnt_q == W_AW'(W_TOTAL - 1)) begin
          w_cnt_q <= '0;
          phase_q <= (HAS_BIAS != 0) ? PH_B : PH_DONE;
        end else begin
          w_cnt_q <= w_cnt_q + 1'b1;
          phase_q <= PH_W;
        end
      end
      if (b_fire) begin
        if (b_cnt_q == ROW_W'(OUT_FEATURES - 1)) begin
          b_cnt_q <= '0;
          phase_q <= PH_DONE;
        end else begin
          b_cnt_q <= b_cnt_q + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (w_fire) begin
      w_mem[w_cnt_q] <= i_w_data;
    end
    if (b_fire) begin
      b_mem[b_cnt_q] <= i_b_data;
    end
  end

  // Row-major storage, so weight[row][col] is read directly
  assign w_rd_addr = W_AW'(i_row * IN_FEATURES + i_col);
  assign o_weight  = w_mem[w_rd_addr];
  assign o_bias    = (HAS_BIAS != 0) ? b_mem[i_row] : '0;
  assign o_loaded  = (phase_q == PH_DONE);

endmodule

//--- design/mac_engine.sv
`timescale 1ns/1ps

module mac_engine #(
  parameter  int IN_FEATURES  = 4,
  parameter  int OUT_FEATURES = 3,
  localparam int COL_W        = linear_pkg::idx_w(IN_FEATURES),
  localparam int ROW_W        = linear_pkg::idx_w(OUT_FEATURES)
) (
  input  logic              clk,
  input  logic              i_rst_n,
  input  logic              i_vec_full,
  input  logic              i_loaded,
  output logic              o_vec_release,
  output logic              o_busy,
  output logic [ROW_W-1:0]  o_row,
  output logic [COL_W-1:0]  o_col,
  input  linear_pkg::elem_t i_elem,
  input  linear_pkg::elem_t i_weight,
  input  linear_pkg::elem_t i_bias,
  output linear_pkg::acc_t  o_acc,
  output logic              o_acc_valid,
  input  logic              i_acc_ready
);

  import linear_pkg::*;

  typedef enum logic [1:0] {ST_IDLE, ST_ACC, ST_HOLD} state_t;

  state_t                     state_q;
  logic [ROW_W-1:0]           row_q;
  logic [COL_W-1:0]           col_q;
  acc_t                       acc_q;
  acc_t                       acc_base;
  acc_t                       bias_aligned;
  logic signed [2*DATA_W-1:0] product;
  logic                       start;
  logic                       last_col;
  logic                       last_row;
  logic                       acc_fire;

  assign start    = (state_q == ST_IDLE) && i_vec_full && i_loaded;
  assign last_col = (col_q == COL_W'(IN_FEATURES - 1));
  assign last_row = (row_q == ROW_W'(OUT_FEATURES - 1));
  assign acc_fire = (state_q == ST_HOLD) && i_acc_ready;

  // Full-precision product, fraction bits add up to ACC_FRAC
  assign product = i_elem * i_weight;

  // Bias brought up to the accumulator fraction
  assign bias_aligned = acc_t'(i_bias) <<< DATA_FRAC;

  // First column of a row starts from the bias
  assign acc_base = (col_q == '0) ? bias_aligned : acc_q;

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      state_q <= ST_IDLE;
      row_q   <= '0;
      col_q   <= '0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (start) begin
            state_q <= ST_ACC;
          end
        end
        ST_ACC: begin
          if (last_col) begin
            col_q   <= '0;
            state_q <= ST_HOLD;
          end else begin
            col_q <= col_q + 1'b1;
          end
        end
        ST_HOLD: begin
          if (acc_fire) begin
            if (last_row) begin
              row_q   <= '0;
              state_q <= ST_IDLE;
            end else begin
              row_q   <= row_q + 1'b1;
              state_q <= ST_ACC;
            end
          end
        end
        default: begin
          state_q <= ST_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == ST_ACC) begin
      acc_q <= acc_base + acc_t'(product);
    end
  end

  assign o_row         = row_q;
  assign o_col         = col_q;
  assign o_acc         = acc_q;
  assign o_acc_valid   = (state_q == ST_HOLD);
  assign o_vec_release = acc_fire && last_row;

  // A waiting vector also holds off a reload of the weights
  assign o_busy = (state_q != ST_IDLE) || (i_vec_full && i_loaded);

endmodule

//--- design/fixed_requantize.sv
`timescale 1ns/1ps

module fixed_requantize (
  input  linear_pkg::acc_t  i_acc,
  output linear_pkg::elem_t o_elem
);

  import linear_pkg::*;

  localparam int SHIFT = ACC_FRAC - DATA_FRAC;

  // One extra bit so the rounding add cannot wrap
  localparam logic signed [ACC_W:0] HALF_LSB = 1 << (SHIFT - 1);
  localparam logic signed [ACC_W:0] ELEM_MAX = (2 ** (DATA_W - 1)) - 1;
  localparam logic signed [ACC_W:0] ELEM_MIN = -(2 ** (DATA_W - 1));

  logic signed [ACC_W:0] rounded;
  logic signed [ACC_W:0] scaled;

  // Round half up, toward positive infinity
  assign rounded = (ACC_W + 1)'(i_acc) + HALF_LSB;
  assign scaled  = rounded >>> SHIFT;

  // Clamp to the element range
  always_comb begin
    if (scaled > ELEM_MAX) begin
      o_elem = ELEM_MAX[DATA_W-1:0];
    end else if (scaled < ELEM_MIN) begin
      o_elem = ELEM_MIN[DATA_W-1:0];
    end else begin
      o_elem = scaled[DATA_W-1:0];
    end
  end

endmodule

//--- design/fixed_linear_top.sv
`timescale 1ns/1ps

module fixed_linear_top #(
  parameter int IN_FEATURES  = 4,
  parameter int OUT_FEATURES = 3,
  parameter int HAS_BIAS     = 1
) (
  input  logic              clk,
  input  logic              i_rst_n,
  input  linear_pkg::elem_t i_w_data,
  input  logic              i_w_valid,
  output logic              o_w_ready,
  input  linear_pkg::elem_t i_b_data,
  input  logic              i_b_valid,
  output logic              o_b_ready,
  input  linear_pkg::elem_t i_x_data,
  input  logic              i_x_valid,
  output logic              o_x_ready,
  output linear_pkg::elem_t o_y_data,
  output logic              o_y_valid,
  input  logic              i_y_ready
);

  import linear_pkg::*;

  localparam int COL_W = idx_w(IN_FEATURES);
  localparam int ROW_W = idx_w(OUT_FEATURES);

  // Input slice to vector buffer
  elem_t            xs_data;
  logic             xs_valid;
  logic             xs_ready;

  // Operands and control around the engine
  elem_t            vec_elem;
  logic             vec_full;
  logic             vec_release;
  elem_t            weight;
  elem_t            bias;
  logic             loaded;
  logic             busy;
  logic [ROW_W-1:0] row;
  logic [COL_W-1:0] col;

  // Engine result into the output slice
  acc_t             acc;
  logic             acc_valid;
  logic             acc_ready;
  elem_t            y_elem;

  stream_register_slice #(
    .T (linear_pkg::elem_t)
  ) u_x_slice (
    .clk     (clk),
    .i_rst_n (i_rst_n),
    .i_data  (i_x_data),
    .i_valid (i_x_valid),
    .o_ready (o_x_ready),
    .o_data  (xs_data),
    .o_valid (xs_valid),
    .i_ready (xs_ready)
  );

  input_vector_buffer #(
    .IN_FEATURES (IN_FEATURES)
  ) u_vec_buf (
    .clk           (clk),
    .i_rst_n       (i_rst_n),
    .i_x_data      (xs_data),
    .i_x_valid     (xs_valid),
    .o_x_ready     (xs_ready),
    .i_addr        (col),
    .o_elem        (vec_elem),
    .o_vec_full    (vec_full),
    .i_vec_release (vec_release)
  );

  weight_store #(
    .IN_FEATURES  (IN_FEATURES),
    .OUT_FEATURES (OUT_FEATURES),
    .HAS_BIAS     (HAS_BIAS)
  ) u_weights (
    .clk       (clk),
    .i_rst_n   (i_rst_n),
    .i_w_data  (i_w_data),
    .i_w_valid (i_w_valid),
    .o_w_ready (o_w_ready),
    .i_b_data  (i_b_data),
    .i_b_valid (i_b_valid),
    .o_b_ready (o_b_ready),
    .i_busy    (busy),
    .i_row     (row),
    .i_col     (col),
    .o_weight  (weight),
    .o_bias    (bias),
    .o_loaded  (loaded)
  );

  mac_engine #(
    .IN_FEATURES  (IN_FEATURES),
    .OUT_FEATURES (OUT_FEATURES)
  ) u_mac (
    .clk           (clk),
    .i_rst_n       (i_rst_n),
    .i_vec_full    (vec_full),
    .i_loaded      (loaded),
    .o_vec_release (vec_release),
    .o_busy        (busy),
    .o_row         (row),
    .o_col         (col),
    .i_elem        (vec_elem),
    .i_weight      (weight),
    .i_bias        (bias),
    .o_acc         (acc),
    .o_acc_valid   (acc_valid),
    .i_acc_ready   (acc_ready)
  );

  // Handshake passes around the requantizer
  fixed_requantize u_requant (
    .i_acc  (acc),
    .o_elem (y_elem)
  );

  stream_register_slice #(
    .T (linear_pkg::elem_t)
  ) u_y_slice (
    .clk     (clk),
    .i_rst_n (i_rst_n),
    .i_data  (y_elem),
    .i_valid (acc_valid),
    .o_ready (acc_ready),
    .o_data  (o_y_data),
    .o_valid (o_y_valid),
    .i_ready (i_y_ready)
  );

endmodule

//--- verif/fixed_linear_asserts.sv
`timescale 1ns/1ps

module fixed_linear_asserts (
  input logic              clk,
  input logic              i_rst_n,
  input logic              o_x_ready,
  input logic              o_y_valid,
  input linear_pkg::elem_t o_y_data,
  input logic              i_y_ready
);

  // Result stream idle while reset holds
  y_idle_in_reset: assert property (@(posedge clk) !i_rst_n |=> !o_y_valid)
    else $error("o_y_valid high during reset");

  // Stalled result keeps its valid and data
  y_stable_on_stall: assert property (@(posedge clk) disable iff (!i_rst_n)
    (o_y_valid && !i_y_ready) |=> (o_y_valid && $stable(o_y_data)))
    else $error("result changed or dropped while stalled");

  // Registered ready comes up one cycle late
  x_ready_after_reset: assert property (@(posedge clk) $rose(i_rst_n) |-> !o_x_ready)
    else $error("o_x_ready high on the first cycle after reset");

endmodule

bind fixed_linear_top fixed_linear_asserts u_asserts (
  .clk       (clk),
  .i_rst_n   (i_rst_n),
  .o_x_ready (o_x_ready),
  .o_y_valid (o_y_valid),
  .o_y_data  (o_y_data),
  .i_y_ready (i_y_ready)
);

//--- verif/tb_fixed_linear.sv
`timescale 1ns/1ps

module tb_fixed_linear;

  import linear_pkg::*;

  localparam int IN_F     = 4;
  localparam int OUT_F    = 3;
  localparam int HAS_BIAS = 1;
  localparam int N_ROWS   = 10;
  localparam int N_WSETS  = 2;
  localparam int SHIFT    = ACC_FRAC - DATA_FRAC;

  // Watchdog budget in clock cycles
  localparam int ROW_CYCLES  = IN_F + OUT_F * (IN_F + 2) * 8;
  localparam int LOAD_CYCLES = 2 * (IN_F * OUT_F + OUT_F);
  localparam int TIMEOUT_CYC = N_ROWS * (ROW_CYCLES + LOAD_CYCLES) + 64;

  logic  clk;
  logic  i_rst_n;
  elem_t i_w_data;
  logic  i_w_valid;
  logic  o_w_ready;
  elem_t i_b_data;
  logic  i_b_valid;
  logic  o_b_ready;
  elem_t i_x_data;
  logic  i_x_valid;
  logic  o_x_ready;
  elem_t o_y_data;
  logic  o_y_valid;
  logic  i_y_ready;

  // Weight sets, row-major, and the test table
  int    w_tab  [N_WSETS][IN_F*OUT_F];
  int    b_tab  [N_WSETS][OUT_F];
  string t_name [N_ROWS];
  int    t_wset [N_ROWS];
  int    t_x    [N_ROWS][IN_F];
  bit    t_bp   [N_ROWS];
  int    t_exp  [N_ROWS][OUT_F];
  int    n_rows;
  int    err_count;
  int    check_count;
  int    seed;

  fixed_linear_top #(
    .IN_FEATURES  (IN_F),
    .OUT_FEATURES (OUT_F),
    .HAS_BIAS     (HAS_BIAS)
  ) DUT (
    .clk       (clk),
    .i_rst_n   (i_rst_n),
    .i_w_data  (i_w_data),
    .i_w_valid (i_w_valid),
    .o_w_ready (o_w_ready),
    .i_b_data  (i_b_data),
    .i_b_valid (i_b_valid),
    .o_b_ready (o_b_ready),
    .i_x_data  (i_x_data),
    .i_x_valid (i_x_valid),
    .o_x_ready (o_x_ready),
    .o_y_data  (o_y_data),
    .o_y_valid (o_y_valid),
    .i_y_ready (i_y_ready)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  initial begin
    repeat (TIMEOUT_CYC) @(posedge clk);
    $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYC);
    $display("FAIL: see errors above");
    $finish;
  end

  task automatic check_value(input string name, input int exp, input int act);
    check_count++;
    if (exp != act) begin
      err_count++;
      $display("FAIL %s expected %0d actual %0d", name, exp, act);
    end
  endtask

  // Wide sum with shifted bias, round half up, saturate
  function automatic int expected_y(input int ws, input int row, input int j);
    int acc;
    int k;
    int r;
    acc = b_tab[ws][j] * (1 << DATA_FRAC);
    for (k = 0; k < IN_F; k++) begin
      acc = acc + w_tab[ws][j*IN_F + k] * t_x[row][k];
    end
    r = (acc + (1 << (SHIFT - 1))) >>> SHIFT;
    if (r > (1 << (DATA_W - 1)) - 1) begin
      r = (1 << (DATA_W - 1)) - 1;
    end else if (r < -(1 << (DATA_W - 1))) begin
      r = -(1 << (DATA_W - 1));
    end
    return r;
  endfunction

  task automatic add_row(input string name, input int ws, input int x0, input int x1,
                         input int x2, input int x3, input bit bp);
    int j;
    t_name[n_rows] = name;
    t_wset[n_rows] = ws;
    t_x[n_rows]    = '{x0, x1, x2, x3};
    t_bp[n_rows]   = bp;
    for (j = 0; j < OUT_F; j++) begin
      t_exp[n_rows][j] = expected_y(ws, n_rows, j);
    end
    n_rows++;
  endtask

  task automatic build_table();
    // Set 0 has even weights, set 1 odd ones for near-half sums
    w_tab[0] = '{16, 0, 0, 0, 8, 8, 8, 8, -16, 16, -16, 16};
    b_tab[0] = '{16, -8, 0};
    w_tab[1] = '{7, 1, 0, 0, 3, -5, 2, 1, 100, -100, 50, -50};
    b_tab[1] = '{0, 8, -16};
    add_row("basic_small", 0, 16, 32, -16, 8, 1'b0);
    add_row("round_half", 0, 1, 16, 0, 0, 1'b0);
    add_row("round_half_neg", 0, 1, 1, 1, 0, 1'b0);
    add_row("saturate_pos", 0, 127, 127, 127, 127, 1'b0);
    add_row("saturate_neg", 0, 127, -128, 127, -128, 1'b0);
    add_row("backpress_a", 0, -40, 25, 3, -7, 1'b1);
    add_row("backpress_b", 0, 64, -64, 17, 99, 1'b1);
    add_row("reload_near", 1, 1, 0, 0, 0, 1'b0);
    add_row("reload_mix", 1, -9, -1, 30, -3, 1'b1);
    add_row("reload_neg", 1, -1, 0, 0, 0, 1'b1);
  endtask

  task automatic load_weights(input int ws);
    int k;
    for (k = 0; k < IN_F * OUT_F; k++) begin
      @(posedge clk);
      #2;
      i_w_valid = 1'b1;
      i_w_data  = elem_t'(w_tab[ws][k]);
      @(negedge clk);
      while (!o_w_ready) @(negedge clk);
    end
    @(posedge clk);
    #2;
    i_w_valid = 1'b0;
    for (k = 0; k < OUT_F; k++) begin
      if (k > 0) begin
        @(posedge clk);
        #2;
      end
      i_b_valid = 1'b1;
      i_b_data  = elem_t'(b_tab[ws][k]);
      @(negedge clk);
      while (!o_b_ready) @(negedge clk);
    end
    @(posedge clk);
    #2;
    i_b_valid = 1'b0;
  endtask

  task automatic send_vector(input int row);
    int k;
    for (k = 0; k < IN_F; k++) begin
      @(posedge clk);
      #2;
      i_x_valid = 1'b1;
      i_x_data  = elem_t'(t_x[row][k]);
      @(negedge clk);
      while (!o_x_ready) @(negedge clk);
    end
    @(posedge clk);
    #2;
    i_x_valid = 1'b0;
  endtask

  // Handshake state is read at the falling edge, before the transfer edge
  task automatic collect_results(input int row);
    int got;
    int rnd;
    got = 0;
    while (got < OUT_F) begin
      @(posedge clk);
      #2;
      if (t_bp[row]) begin
        rnd       = $random(seed);
        i_y_ready = ((rnd & 3) != 0);
      end else begin
        i_y_ready = 1'b1;
      end
      @(negedge clk);
      if (o_y_valid && i_y_ready) begin
        // Engine still owes the later features here
        if (got == 0) begin
          check_value($sformatf("%s w_ready", t_name[row]), 0, int'(o_w_ready));
        end
        check_value($sformatf("%s y[%0d]", t_name[row], got), t_exp[row][got], o_y_data);
        got++;
      end
    end
    @(posedge clk);
    #2;
    i_y_ready = 1'b0;
  endtask

  initial begin
    int i;
    int errs_before;
    int cur_wset;
    i_rst_n     = 1'b0;
    i_w_data    = '0;
    i_w_valid   = 1'b0;
    i_b_data    = '0;
    i_b_valid   = 1'b0;
    i_x_data    = '0;
    i_x_valid   = 1'b0;
    i_y_ready   = 1'b0;
    n_rows      = 0;
    err_count   = 0;
    check_count = 0;
    seed        = 32'h2398;
    build_table();

    repeat (15) @(posedge clk);
    @(negedge clk);
    check_value("reset_state y_valid", 0, int'(o_y_valid));
    check_value("reset_state x_ready", 0, int'(o_x_ready));
    check_value("reset_state w_ready", 0, int'(o_w_ready));
    check_value("reset_state b_ready", 0, int'(o_b_ready));
    @(posedge clk);
    #2;
    i_rst_n = 1'b1;
    $display("%-20s done, %0d mismatches", "reset_state", err_count);

    // First row's vector offered before any weights exist
    errs_before = err_count;
    send_vector(0);
    repeat (20) begin
      @(negedge clk);
      check_value("no_output_unloaded", 0, int'(o_y_valid));
    end
    $display("%-20s done, %0d mismatches", "no_output_unloaded", err_count - errs_before);

    cur_wset = -1;
    for (i = 0; i < n_rows; i++) begin
      errs_before = err_count;
      if (t_wset[i] != cur_wset) begin
        load_weights(t_wset[i]);
        cur_wset = t_wset[i];
      end
      fork
        begin
          if (i != 0) begin
            send_vector(i);
          end
        end
        collect_results(i);
      join
      $display("%-20s done, %0d mismatches", t_name[i], err_count - errs_before);
    end

    $display("Summary: %0d tests, %0d checks, %0d errors", n_rows + 2, check_count, err_count);
    if (err_count == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

//--- fixed_linear_top.f
design/linear_pkg.sv
design/stream_register_slice.sv
design/input_vector_buffer.sv
design/weight_store.sv
design/mac_engine.sv
design/fixed_requantize.sv
design/fixed_linear_top.sv
verif/fixed_linear_asserts.sv
verif/tb_fixed_linear.sv

//--- Makefile
SIM      := verilator
SIMFLAGS := --binary --timing --assert -Wno-fatal
TOP      := tb_fixed_linear
FLIST    := fixed_linear_top.f
BUILD    := obj_dir
LOG      := sim.log
PASS_MSG := PASS: all tests

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(SIM) $(SIMFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD) -o V$(TOP)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)
